// File: list.f
+incdir+include
hdl/xbar_pkg.sv
hdl/cpu_read_router.sv
hdl/dram_read_arbiter.sv
hdl/lite_read_bridge.sv
hdl/axi_read_interconnect.sv
verification/tb_axi_read_interconnect.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the read crossbar testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    -f list.f \
    --top-module tb_axi_read_interconnect \
    --Mdir "$OBJ" -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: verification/tb_axi_read_interconnect.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module tb_axi_read_interconnect;

    localparam int CLK_PERIOD   = 40;
    localparam int SAMPLE_DELAY = CLK_PERIOD / 2 - 1;
    localparam int N_TXN        = 200;
    localparam int WATCHDOG_NS  = 2 * N_TXN * 40 * CLK_PERIOD;
    localparam logic [31:0] CORDIC_KEY = 32'hC0D1_C000;
    localparam logic [31:0] SA_KEY     = 32'h5A00_0000;

    logic   ACLK;
    logic   ARESETN;
    integer seed;

    // Index 0 is S0 and index 1 is S1
    xbar_pkg::ar_req_t  mgr_ar [2];
    logic               mgr_arvalid [2];
    logic               mgr_arready [2];
    xbar_pkg::r_beat_t  mgr_r [2];
    logic               mgr_rvalid [2];
    logic               mgr_rready [2];

    // Lite target 0 is M0 (CORDIC) and 1 is M1 (SA)
    xbar_pkg::lite_ar_t lite_ar [2];
    logic               lite_arvalid [2];
    logic               lite_arready [2];
    xbar_pkg::lite_r_t  lite_r [2];
    logic               lite_rvalid [2];
    logic               lite_rready [2];

    xbar_pkg::ar_req_t  m2_ar;
    logic               m2_arvalid;
    logic               m2_arready;
    xbar_pkg::r_beat_t  m2_r;
    logic               m2_rvalid;
    logic               m2_rready;

    // Manager and reference state
    int                 issued [2];
    int                 done [2];
    logic               outstanding [2];
    logic               mgr_taken [2];
    xbar_pkg::r_beat_t  exp_s0 [$];
    xbar_pkg::r_beat_t  exp_s1 [$];
    xbar_pkg::ar_req_t  lite_want [2];
    logic               lite_want_v [2];
    logic               last_served_s1;
    logic               dram_busy;

    // Target model state
    logic               lite_busy [2];
    int                 lite_delay [2];
    xbar_pkg::lite_r_t  lite_beat [2];
    xbar_pkg::r_beat_t  dram_q [$];
    logic               dram_beat_taken;

    axi_read_interconnect axi_read_interconnect_i (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .s0_ar      (mgr_ar[0]),
        .s0_arvalid (mgr_arvalid[0]),
        .s0_arready (mgr_arready[0]),
        .s0_r       (mgr_r[0]),
        .s0_rvalid  (mgr_rvalid[0]),
        .s0_rready  (mgr_rready[0]),
        .s1_ar      (mgr_ar[1]),
        .s1_arvalid (mgr_arvalid[1]),
        .s1_arready (mgr_arready[1]),
        .s1_r       (mgr_r[1]),
        .s1_rvalid  (mgr_rvalid[1]),
        .s1_rready  (mgr_rready[1]),
        .m0_ar      (lite_ar[0]),
        .m0_arvalid (lite_arvalid[0]),
        .m0_arready (lite_arready[0]),
        .m0_r       (lite_r[0]),
        .m0_rvalid  (lite_rvalid[0]),
        .m0_rready  (lite_rready[0]),
        .m1_ar      (lite_ar[1]),
        .m1_arvalid (lite_arvalid[1]),
        .m1_arready (lite_arready[1]),
        .m1_r       (lite_r[1]),
        .m1_rvalid  (lite_rvalid[1]),
        .m1_rready  (lite_rready[1]),
        .m2_ar      (m2_ar),
        .m2_arvalid (m2_arvalid),
        .m2_arready (m2_arready),
        .m2_r       (m2_r),
        .m2_rvalid  (m2_rvalid),
        .m2_rready  (m2_rready)
    );

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[ERROR] %0t %s expected %h actual %h",
                                $time, name, expected, actual));
        end
    endtask

    // Address map of S0
    function automatic xbar_pkg::target_e target_of(input logic [31:0] addr);
        if (longint'(addr) >= longint'(`XBAR_SA_LO) &&
            longint'(addr) <= longint'(`XBAR_SA_HI)) begin
            return xbar_pkg::TGT_SA;
        end
        if (longint'(addr) >= longint'(`XBAR_CORDIC_LO) &&
            longint'(addr) <= longint'(`XBAR_CORDIC_HI)) begin
            return xbar_pkg::TGT_CORDIC;
        end
        return xbar_pkg::TGT_DRAM;
    endfunction

    function automatic logic [31:0] lite_key(input int t);
        return (t == 0) ? CORDIC_KEY : SA_KEY;
    endfunction

    // Beat k of a DRAM burst
    function automatic xbar_pkg::r_beat_t dram_beat(input xbar_pkg::ar_req_t req, input int k);
        xbar_pkg::r_beat_t b;
        b.id   = req.id;
        b.data = req.addr + 32'(k);
        b.resp = 2'b00;
        b.last = (k == int'(req.len));
        return b;
    endfunction

    task automatic push_expected(input int m, input xbar_pkg::r_beat_t b);
        if (m == 0) begin
            exp_s0.push_back(b);
        end else begin
            exp_s1.push_back(b);
        end
    endtask

    task automatic take_expected(input int m, output xbar_pkg::r_beat_t b);
        if ((m == 0 && exp_s0.size() == 0) || (m == 1 && exp_s1.size() == 0)) begin
            abort_run($sformatf("%0t: S%0d got a read beat it never asked for", $time, m));
        end else if (m == 0) begin
            b = exp_s0.pop_front();
        end else begin
            b = exp_s1.pop_front();
        end
    endtask

    // Small addresses hit the register windows and the rest go to DRAM
    task automatic make_request(input int m, output xbar_pkg::ar_req_t q);
        logic [31:0] r;
        logic [31:0] wide;
        r     = $random(seed);
        wide  = $random(seed);
        q.id    = r[3:0];
        q.size  = 3'd2;
        q.burst = 2'b01;
        q.addr  = (r[7:4] > 4'd2) ? {28'd0, r[11:8]} : wide;
        if (m == 0 && target_of(q.addr) != xbar_pkg::TGT_DRAM) begin
            q.len = 8'd0;
        end else begin
            q.len = {6'd0, r[13:12]};
        end
    endtask

    task automatic check_quiet();
        compare("m0_arvalid", 64'd0, 64'(lite_arvalid[0]));
        compare("m1_arvalid", 64'd0, 64'(lite_arvalid[1]));
        compare("m2_arvalid", 64'd0, 64'(m2_arvalid));
        compare("s0_rvalid", 64'd0, 64'(mgr_rvalid[0]));
        compare("s1_rvalid", 64'd0, 64'(mgr_rvalid[1]));
    endtask

    // Managers and target models update their outputs on the falling edge
    task automatic drive_inputs();
        logic [31:0]       r;
        xbar_pkg::ar_req_t req;
        for (int m = 0; m < 2; m++) begin
            if (mgr_taken[m]) begin
                mgr_arvalid[m] = 1'b0;
                mgr_taken[m]   = 1'b0;
            end
            r = $random(seed);
            if (!mgr_arvalid[m] && issued[m] < N_TXN && r[0]) begin
                make_request(m, req);
                mgr_ar[m]      = req;
                mgr_arvalid[m] = 1'b1;
                issued[m]++;
            end
            mgr_rready[m] = (r[2:1] != 2'b00);
        end
        for (int t = 0; t < 2; t++) begin
            r = $random(seed);
            lite_arready[t] = (r[1:0] != 2'b00);
            if (!lite_busy[t]) begin
                lite_rvalid[t] = 1'b0;
            end else if (lite_delay[t] > 0) begin
                lite_delay[t]--;
            end else begin
                lite_rvalid[t] = 1'b1;
                lite_r[t]      = lite_beat[t];
            end
        end
        r = $random(seed);
        m2_arready = (r[1:0] != 2'b00);
        // A shown beat stays until it is taken
        if (dram_q.size() == 0) begin
            m2_rvalid = 1'b0;
        end else if (!m2_rvalid || dram_beat_taken) begin
            m2_rvalid = (r[3:2] != 2'b00);
        end
        if (dram_q.size() != 0) begin
            m2_r = dram_q[0];
        end
        dram_beat_taken = 1'b0;
    endtask

    // Record and check handshakes just before the rising edge
    task automatic observe();
        logic [1:0]         hs;
        logic [1:0]         vis;
        logic [1:0]         from_dram;
        int                 winner;
        logic [31:0]        r;
        xbar_pkg::target_e  tgt;
        xbar_pkg::r_beat_t  beat;
        if (dram_busy && m2_arvalid) begin
            abort_run($sformatf("%0t: second M2 request during an open burst", $time));
        end
        tgt    = target_of(mgr_ar[0].addr);
        vis[0] = mgr_arvalid[0] && !outstanding[0] && tgt == xbar_pkg::TGT_DRAM;
        vis[1] = mgr_arvalid[1];
        for (int m = 0; m < 2; m++) begin
            hs[m] = mgr_arvalid[m] && mgr_arready[m];
            if (hs[m] && outstanding[m]) begin
                abort_run($sformatf("%0t: S%0d had a read accepted before the previous one ended",
                                    $time, m));
            end
            if (hs[m]) begin
                outstanding[m] = 1'b1;
                mgr_taken[m]   = 1'b1;
            end
        end
        from_dram[0] = hs[0] && tgt == xbar_pkg::TGT_DRAM;
        from_dram[1] = hs[1];
        if (hs[0] && tgt != xbar_pkg::TGT_DRAM) begin
            lite_want[tgt == xbar_pkg::TGT_SA]   = mgr_ar[0];
            lite_want_v[tgt == xbar_pkg::TGT_SA] = 1'b1;
        end

        // The manager not served last wins a tie
        if (m2_arvalid && m2_arready) begin
            if (vis == 2'b00) begin
                abort_run($sformatf("%0t: M2 request with no manager waiting", $time));
            end
            winner = (vis == 2'b11) ? (last_served_s1 ? 0 : 1) : (vis[1] ? 1 : 0);
            compare("s0_arready", 64'(winner == 0), 64'(from_dram[0]));
            compare("s1_arready", 64'(winner == 1), 64'(from_dram[1]));
            compare("m2_ar", 64'(mgr_ar[winner]), 64'(m2_ar));
            for (int k = 0; k <= int'(m2_ar.len); k++) begin
                dram_q.push_back(dram_beat(m2_ar, k));
                push_expected(winner, dram_beat(mgr_ar[winner], k));
            end
            dram_busy      = 1'b1;
            last_served_s1 = (winner == 1);
        end else if (from_dram != 2'b00) begin
            abort_run($sformatf("%0t: DRAM read accepted without an M2 request", $time));
        end

        for (int t = 0; t < 2; t++) begin
            if (lite_arvalid[t] && lite_arready[t]) begin
                if (!lite_want_v[t]) begin
                    abort_run($sformatf("%0t: unexpected read request on M%0d", $time, t));
                end
                compare($sformatf("m%0d_ar.addr", t), 64'(lite_want[t].addr),
                        64'(lite_ar[t].addr));
                compare($sformatf("m%0d_ar.prot", t), 64'd0, 64'(lite_ar[t].prot));
                r = $random(seed);
                lite_beat[t].data = lite_ar[t].addr ^ lite_key(t);
                lite_beat[t].resp = r[1:0];
                lite_delay[t]     = {29'd0, r[4:2]};
                lite_busy[t]      = 1'b1;
                // Lite beat comes back with the original ID and a clean upper resp bit
                beat.id   = lite_want[t].id;
                beat.data = lite_want[t].addr ^ lite_key(t);
                beat.resp = {1'b0, r[0]};
                beat.last = 1'b1;
                push_expected(0, beat);
                lite_want_v[t] = 1'b0;
            end else if (lite_want_v[t]) begin
                abort_run($sformatf("%0t: S0 read accepted but missing on M%0d", $time, t));
            end
            if (lite_rvalid[t] && lite_rready[t]) begin
                lite_busy[t] = 1'b0;
            end
        end

        if (m2_rvalid && m2_rready) begin
            beat = dram_q.pop_front();
            dram_beat_taken = 1'b1;
            if (beat.last) begin
                dram_busy = 1'b0;
            end
        end

        for (int m = 0; m < 2; m++) begin
            if (mgr_rvalid[m] && mgr_rready[m]) begin
                take_expected(m, beat);
                compare($sformatf("s%0d_r", m), 64'(beat), 64'(mgr_r[m]));
                if (beat.last) begin
                    outstanding[m] = 1'b0;
                    done[m]++;
                end
            end
        end
    endtask

    initial begin
        seed    = 32'he078_96ed;
        ACLK    = 1'b0;
        ARESETN = 1'b0;
        for (int i = 0; i < 2; i++) begin
            mgr_ar[i]       = '0;
            mgr_arvalid[i]  = 1'b0;
            mgr_rready[i]   = 1'b0;
            lite_arready[i] = 1'b0;
            lite_r[i]       = '0;
            lite_rvalid[i]  = 1'b0;
            issued[i]       = 0;
            done[i]         = 0;
            outstanding[i]  = 1'b0;
            mgr_taken[i]    = 1'b0;
            lite_want_v[i]  = 1'b0;
            lite_busy[i]    = 1'b0;
            lite_delay[i]   = 0;
        end
        m2_arready      = 1'b0;
        m2_r            = '0;
        m2_rvalid       = 1'b0;
        last_served_s1  = 1'b1;
        dram_busy       = 1'b0;
        dram_beat_taken = 1'b0;

        repeat (8) begin
            @(negedge ACLK);
            check_quiet();
        end
        ARESETN = 1'b1;
        #(SAMPLE_DELAY);
        check_quiet();

        while (done[0] < N_TXN || done[1] < N_TXN) begin
            @(negedge ACLK);
            drive_inputs();
            #(SAMPLE_DELAY);
            observe();
        end

        if (dram_q.size() != 0 || lite_busy[0] || lite_busy[1]) begin
            abort_run("Target models still hold responses after the last read");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // Watchdog sized from the number of reads
    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the reads did not complete in the expected time");
    end

endmodule

// File: hdl/axi_read_interconnect.sv
`timescale 1ns/1ps

module axi_read_interconnect (
    input  logic                ACLK,
    input  logic                ARESETN,
    // S0 from the processor
    input  xbar_pkg::ar_req_t   s0_ar,
    input  logic                s0_arvalid,
    output logic                s0_arready,
    output xbar_pkg::r_beat_t   s0_r,
    output logic                s0_rvalid,
    input  logic                s0_rready,
    // S1 from the systolic array
    input  xbar_pkg::ar_req_t   s1_ar,
    input  logic                s1_arvalid,
    output logic                s1_arready,
    output xbar_pkg::r_beat_t   s1_r,
    output logic                s1_rvalid,
    input  logic                s1_rready,
    // M0 to CORDIC over AXI4-Lite
    output xbar_pkg::lite_ar_t  m0_ar,
    output logic                m0_arvalid,
    input  logic                m0_arready,
    input  xbar_pkg::lite_r_t   m0_r,
    input  logic                m0_rvalid,
    output logic                m0_rready,
    // M1 to the systolic array registers over AXI4-Lite
    output xbar_pkg::lite_ar_t  m1_ar,
    output logic                m1_arvalid,
    input  logic                m1_arready,
    input  xbar_pkg::lite_r_t   m1_r,
    input  logic                m1_rvalid,
    output logic                m1_rready,
    // M2 to the DRAM controller
    output xbar_pkg::ar_req_t   m2_ar,
    output logic                m2_arvalid,
    input  logic                m2_arready,
    input  xbar_pkg::r_beat_t   m2_r,
    input  logic                m2_rvalid,
    output logic                m2_rready
);

    xbar_pkg::ar_req_t  sa_ar;
    logic               sa_arvalid;
    logic               sa_arready;
    xbar_pkg::r_beat_t  sa_r;
    logic               sa_rvalid;
    logic               sa_rready;

    xbar_pkg::ar_req_t  cordic_ar;
    logic               cordic_arvalid;
    logic               cordic_arready;
    xbar_pkg::r_beat_t  cordic_r;
    logic               cordic_rvalid;
    logic               cordic_rready;

    // S0 share of the DRAM port
    xbar_pkg::ar_req_t  dram_ar;
    logic               dram_arvalid;
    logic               dram_arready;
    xbar_pkg::r_beat_t  dram_r;
    logic               dram_rvalid;
    logic               dram_rready;

    cpu_read_router cpu_read_router_i (
        .ACLK           (ACLK),
        .ARESETN        (ARESETN),
        .s_ar           (s0_ar),
        .s_arvalid      (s0_arvalid),
        .s_arready      (s0_arready),
        .s_r            (s0_r),
        .s_rvalid       (s0_rvalid),
        .s_rready       (s0_rready),
        .sa_ar          (sa_ar),
        .sa_arvalid     (sa_arvalid),
        .sa_arready     (sa_arready),
        .sa_r           (sa_r),
        .sa_rvalid      (sa_rvalid),
        .sa_rready      (sa_rready),
        .cordic_ar      (cordic_ar),
        .cordic_arvalid (cordic_arvalid),
        .cordic_arready (cordic_arready),
        .cordic_r       (cordic_r),
        .cordic_rvalid  (cordic_rvalid),
        .cordic_rready  (cordic_rready),
        .dram_ar        (dram_ar),
        .dram_arvalid   (dram_arvalid),
        .dram_arready   (dram_arready),
        .dram_r         (dram_r),
        .dram_rvalid    (dram_rvalid),
        .dram_rready    (dram_rready)
    );

    // S1 goes straight to the arbiter
    dram_read_arbiter dram_read_arbiter_i (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .a_ar      (dram_ar),
        .a_arvalid (dram_arvalid),
        .a_arready (dram_arready),
        .a_r       (dram_r),
        .a_rvalid  (dram_rvalid),
        .a_rready  (dram_rready),
        .b_ar      (s1_ar),
        .b_arvalid (s1_arvalid),
        .b_arready (s1_arready),
        .b_r       (s1_r),
        .b_rvalid  (s1_rvalid),
        .b_rready  (s1_rready),
        .m_ar      (m2_ar),
        .m_arvalid (m2_arvalid),
        .m_arready (m2_arready),
        .m_r       (m2_r),
        .m_rvalid  (m2_rvalid),
        .m_rready  (m2_rready)
    );

    lite_read_bridge sa_bridge_i (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .s_ar      (sa_ar),
        .s_arvalid (sa_arvalid),
        .s_arready (sa_arready),
        .s_r       (sa_r),
        .s_rvalid  (sa_rvalid),
        .s_rready  (sa_rready),
        .m_ar      (m1_ar),
        .m_arvalid (m1_arvalid),
        .m_arready (m1_arready),
        .m_r       (m1_r),
        .m_rvalid  (m1_rvalid),
        .m_rready  (m1_rready)
    );

    lite_read_bridge cordic_bridge_i (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .s_ar      (cordic_ar),
        .s_arvalid (cordic_arvalid),
        .s_arready (cordic_arready),
        .s_r       (cordic_r),
        .s_rvalid  (cordic_rvalid),
        .s_rready  (cordic_rready),
        .m_ar      (m0_ar),
        .m_arvalid (m0_arvalid),
        .m_arready (m0_arready),
        .m_r       (m0_r),
        .m_rvalid  (m0_rvalid),
        .m_rready  (m0_rready)
    );

endmodule

// File: hdl/lite_read_bridge.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module lite_read_bridge (
    input  logic                ACLK,
    input  logic                ARESETN,
    input  xbar_pkg::ar_req_t   s_ar,
    input  logic                s_arvalid,
    output logic                s_arready,
    output xbar_pkg::r_beat_t   s_r,
    output logic                s_rvalid,
    input  logic                s_rready,
    output xbar_pkg::lite_ar_t  m_ar,
    output logic                m_arvalid,
    input  logic                m_arready,
    input  xbar_pkg::lite_r_t   m_r,
    input  logic                m_rvalid,
    output logic                m_rready
);

    logic [`XBAR_ID_W-1:0] id_q;

    // Lite request carries only the address with unprivileged secure data access
    assign m_ar.addr = s_ar.addr;
    assign m_ar.prot = 3'b000;
    assign m_arvalid = s_arvalid;
    assign s_arready = m_arready;

    // Lite has no ID so it is kept for the response
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            id_q <= '0;
        end else if (s_arvalid && s_arready) begin
            id_q <= s_ar.id;
        end
    end

    // Rebuild a single-beat AXI4 response
    assign s_r.id   = id_q;
    assign s_r.data = m_r.data;
    assign s_r.resp = {1'b0, m_r.resp[0]};
    assign s_r.last = 1'b1;
    assign s_rvalid = m_rvalid;
    assign m_rready = s_rready;

    // Lite targets answer one beat per request
    a_single_beat: assert property (@(posedge ACLK) disable iff (!ARESETN)
        s_arvalid && s_arready |-> s_ar.len == '0);

endmodule

// File: hdl/dram_read_arbiter.sv
`timescale 1ns/1ps

module dram_read_arbiter (
    input  logic               ACLK,
    input  logic               ARESETN,
    input  xbar_pkg::ar_req_t  a_ar,
    input  logic               a_arvalid,
    output logic               a_arready,
    output xbar_pkg::r_beat_t  a_r,
    output logic               a_rvalid,
    input  logic               a_rready,
    input  xbar_pkg::ar_req_t  b_ar,
    input  logic               b_arvalid,
    output logic               b_arready,
    output xbar_pkg::r_beat_t  b_r,
    output logic               b_rvalid,
    input  logic               b_rready,
    output xbar_pkg::ar_req_t  m_ar,
    output logic               m_arvalid,
    input  logic               m_arready,
    input  xbar_pkg::r_beat_t  m_r,
    input  logic               m_rvalid,
    output logic               m_rready
);

    // Burst in progress and who owns it
    logic busy;
    logic owner_b;
    // Port b was the last one granted
    logic last_b;
    logic sel_b;
    logic ar_fire;
    logic last_fire;

    // Round robin where a lone requester always wins
    assign sel_b = b_arvalid && (!a_arvalid || !last_b);

    assign m_ar      = sel_b ? b_ar : a_ar;
    assign m_arvalid = !busy && (a_arvalid || b_arvalid);
    assign a_arready = !busy && !sel_b && m_arready;
    assign b_arready = !busy && sel_b && m_arready;

    assign ar_fire   = m_arvalid && m_arready;
    assign last_fire = m_rvalid && m_rready && m_r.last;

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            busy    <= 1'b0;
            owner_b <= 1'b0;
            // S0 takes the first tie
            last_b  <= 1'b1;
        end else if (ar_fire) begin
            busy    <= 1'b1;
            owner_b <= sel_b;
            last_b  <= sel_b;
        end else if (last_fire) begin
            busy <= 1'b0;
        end
    end

    // Beats go to the owner only
    assign a_r = m_r;
    assign b_r = m_r;

    assign a_rvalid = busy && !owner_b && m_rvalid;
    assign b_rvalid = busy && owner_b && m_rvalid;
    assign m_rready = busy && (owner_b ? b_rready : a_rready);

    // DRAM beats only arrive inside an owned burst
    a_beat_in_burst: assert property (@(posedge ACLK) disable iff (!ARESETN)
        m_rvalid |-> busy);

endmodule

// File: hdl/cpu_read_router.sv
`timescale 1ns/1ps
`include "xbar_defines.svh"

module cpu_read_router (
    input  logic               ACLK,
    input  logic               ARESETN,
    input  xbar_pkg::ar_req_t  s_ar,
    input  logic               s_arvalid,
    output logic               s_arready,
    output xbar_pkg::r_beat_t  s_r,
    output logic               s_rvalid,
    input  logic               s_rready,
    output xbar_pkg::ar_req_t  sa_ar,
    output logic               sa_arvalid,
    input  logic               sa_arready,
    input  xbar_pkg::r_beat_t  sa_r,
    input  logic               sa_rvalid,
    output logic               sa_rready,
    output xbar_pkg::ar_req_t  cordic_ar,
    output logic               cordic_arvalid,
    input  logic               cordic_arready,
    input  xbar_pkg::r_beat_t  cordic_r,
    input  logic               cordic_rvalid,
    output logic               cordic_rready,
    output xbar_pkg::ar_req_t  dram_ar,
    output logic               dram_arvalid,
    input  logic               dram_arready,
    input  xbar_pkg::r_beat_t  dram_r,
    input  logic               dram_rvalid,
    output logic               dram_rready
);

    logic                busy;
    xbar_pkg::target_e   tgt_d;
    xbar_pkg::target_e   tgt_q;
    logic                stray_rvalid;

    // Address map decode with DRAM as the default
    always_comb begin
        if ((s_ar.addr - `XBAR_SA_LO) <= (`XBAR_SA_HI - `XBAR_SA_LO)) begin
            tgt_d = xbar_pkg::TGT_SA;
        end else if ((s_ar.addr - `XBAR_CORDIC_LO) <= (`XBAR_CORDIC_HI - `XBAR_CORDIC_LO)) begin
            tgt_d = xbar_pkg::TGT_CORDIC;
        end else begin
            tgt_d = xbar_pkg::TGT_DRAM;
        end
    end

    // Request payload fans out and only the decoded target sees valid
    assign sa_ar     = s_ar;
    assign cordic_ar = s_ar;
    assign dram_ar   = s_ar;

    assign sa_arvalid     = s_arvalid && !busy && (tgt_d == xbar_pkg::TGT_SA);
    assign cordic_arvalid = s_arvalid && !busy && (tgt_d == xbar_pkg::TGT_CORDIC);
    assign dram_arvalid   = s_arvalid && !busy && (tgt_d == xbar_pkg::TGT_DRAM);

    always_comb begin
        case (tgt_d)
            xbar_pkg::TGT_SA:     s_arready = !busy && sa_arready;
            xbar_pkg::TGT_CORDIC: s_arready = !busy && cordic_arready;
            default:              s_arready = !busy && dram_arready;
        endcase
    end

    // Response path follows the latched target
    always_comb begin
        case (tgt_q)
            xbar_pkg::TGT_SA: begin
                s_r      = sa_r;
                s_rvalid = busy && sa_rvalid;
            end
            xbar_pkg::TGT_CORDIC: begin
                s_r      = cordic_r;
                s_rvalid = busy && cordic_rvalid;
            end
            default: begin
                s_r      = dram_r;
                s_rvalid = busy && dram_rvalid;
            end
        endcase
    end

    assign sa_rready     = busy && (tgt_q == xbar_pkg::TGT_SA) && s_rready;
    assign cordic_rready = busy && (tgt_q == xbar_pkg::TGT_CORDIC) && s_rready;
    assign dram_rready   = busy && (tgt_q == xbar_pkg::TGT_DRAM) && s_rready;

    // One read in flight until its last beat is taken
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            busy  <= 1'b0;
            tgt_q <= xbar_pkg::TGT_DRAM;
        end else if (s_arvalid && s_arready) begin
            busy  <= 1'b1;
            tgt_q <= tgt_d;
        end else if (s_rvalid && s_rready && s_r.last) begin
            busy <= 1'b0;
        end
    end

    // Targets must stay quiet unless they own the route
    assign stray_rvalid = (sa_rvalid && !(busy && tgt_q == xbar_pkg::TGT_SA)) ||
                          (cordic_rvalid && !(busy && tgt_q == xbar_pkg::TGT_CORDIC)) ||
                          (dram_rvalid && !(busy && tgt_q == xbar_pkg::TGT_DRAM));

    a_s_ar_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
        s_arvalid && !s_arready |=> $stable(s_ar));

    a_no_stray_rvalid: assert property (@(posedge ACLK) disable iff (!ARESETN)
        !stray_rvalid);

endmodule

// File: hdl/xbar_pkg.sv
`include "xbar_defines.svh"

package xbar_pkg;

    // AXI4 read address channel
    typedef struct packed {
        logic [`XBAR_ID_W-1:0]   id;
        logic [`XBAR_ADDR_W-1:0] addr;
        logic [`XBAR_LEN_W-1:0]  len;
        logic [2:0]              size;
        logic [1:0]              burst;
    } ar_req_t;

    // AXI4 read data channel
    typedef struct packed {
        logic [`XBAR_ID_W-1:0]   id;
        logic [`XBAR_DATA_W-1:0] data;
        logic [1:0]              resp;
        logic                    last;
    } r_beat_t;

    // AXI4-Lite read address channel
    typedef struct packed {
        logic [`XBAR_ADDR_W-1:0] addr;
        logic [2:0]              prot;
    } lite_ar_t;

    // AXI4-Lite read data channel
    typedef struct packed {
        logic [`XBAR_DATA_W-1:0] data;
        logic [1:0]              resp;
    } lite_r_t;

    // Route target of an S0 read
    typedef enum logic [1:0] {
        TGT_SA,
        TGT_CORDIC,
        TGT_DRAM
    } target_e;

endpackage

// File: include/xbar_defines.svh
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// Channel field widths
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32
`define XBAR_ID_W   4
`define XBAR_LEN_W  8

// Systolic array register window
`define XBAR_SA_LO 32'h0000_0000
`define XBAR_SA_HI 32'h0000_0005

// CORDIC register window
`define XBAR_CORDIC_LO 32'h0000_0006
`define XBAR_CORDIC_HI 32'h0000_0009

// Everything outside both windows belongs to DRAM

`endif
